// File: src/fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// Direct-mapped, one 64-bit beat per line
`define ICACHE_LINES 16

// SRAM window, fetched around the cache
`define UNCACHED_BASE  32'h0f00_0000
`define UNCACHED_LIMIT 32'h0f00_2000

`define CACHED_BASE  32'h8000_0000
`define CACHED_LIMIT 32'h8000_0800

// Both regions alias these beats through address bits 10 to 3
`define MEM_BEATS 256

`define MEM_LATENCY 2 // Accepting edge to response

`endif

// File: src/fetch_pkg.sv
package fetch_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] inst_t;
	typedef logic [63:0] beat_t;
	typedef logic [1:0]  resp_t; // Bit 1 set marks an error

	typedef enum logic [2:0] {
		IF_IDLE,
		IF_LOOKUP,
		IF_REFILL,
		IF_BYPASS,
		IF_DELIVER
	} ifu_state_t;

	typedef enum logic {
		MEM_IDLE,
		MEM_BUSY
	} mem_state_t;

	// Bus owner: 0 fetch unit, 1 data port
	typedef logic grant_t;

endpackage

// File: src/icache.sv
`include "fetch_defines.svh"

module icache (
	input  logic             clock,
	input  logic             reset,

	input  fetch_pkg::addr_t lookup_addr,
	output logic             hit,
	output fetch_pkg::inst_t hit_word,

	input  logic             fill_en,
	input  fetch_pkg::addr_t fill_addr,
	input  fetch_pkg::beat_t fill_beat
);

	localparam int ADDR_BITS  = $bits(fetch_pkg::addr_t);
	localparam int INDEX_BITS = $clog2(`ICACHE_LINES);
	localparam int TAG_LSB    = INDEX_BITS + 3;
	localparam int TAG_BITS   = ADDR_BITS - TAG_LSB;

	logic [`ICACHE_LINES-1:0] valid;
	logic [TAG_BITS-1:0]      tags [`ICACHE_LINES];
	fetch_pkg::beat_t         lines [`ICACHE_LINES];

	logic [INDEX_BITS-1:0] rd_index;
	logic [TAG_BITS-1:0]   rd_tag;
	logic [INDEX_BITS-1:0] wr_index;
	logic [TAG_BITS-1:0]   wr_tag;
	fetch_pkg::beat_t      rd_beat;

	assign rd_index = lookup_addr[TAG_LSB-1:3];
	assign rd_tag   = lookup_addr[ADDR_BITS-1:TAG_LSB];
	assign wr_index = fill_addr[TAG_LSB-1:3];
	assign wr_tag   = fill_addr[ADDR_BITS-1:TAG_LSB];
	assign rd_beat  = lines[rd_index];

	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= '0;
			hit   <= 1'b0;
		end else begin
			hit <= valid[rd_index] && (tags[rd_index] == rd_tag);
			if (fill_en) begin
				valid[wr_index] <= 1'b1;
			end
		end
	end

	// Line storage and the read word
	always_ff @(posedge clock) begin
		if (fill_en) begin
			tags[wr_index]  <= wr_tag;
			lines[wr_index] <= fill_beat;
		end
		hit_word <= lookup_addr[2] ? rd_beat[63:32] : rd_beat[31:0]; // Lane by PC bit 2
	end

endmodule

// File: src/ifu.sv
`include "fetch_defines.svh"

module ifu (
	input  logic             clock,
	input  logic             reset,

	input  logic             fetch_valid,
	input  fetch_pkg::addr_t pc,
	output logic             fetch_ready,

	output logic             inst_valid,
	output fetch_pkg::inst_t inst,
	output logic             inst_err,
	input  logic             inst_ready,

	output fetch_pkg::addr_t lookup_addr,
	input  logic             hit,
	input  fetch_pkg::inst_t hit_word,
	output logic             fill_en,
	output fetch_pkg::addr_t fill_addr,
	output fetch_pkg::beat_t fill_beat,

	output logic             if_valid,
	output fetch_pkg::addr_t if_addr,
	input  logic             if_ready,
	input  logic             if_rvalid,
	input  fetch_pkg::beat_t if_rdata,
	input  fetch_pkg::resp_t if_resp
);

	fetch_pkg::ifu_state_t state;
	fetch_pkg::addr_t      pc_q;
	logic                  probe_done; // Cache answer visible in this LOOKUP cycle
	logic                  req_sent;
	logic                  pc_in_sram;
	logic                  bus_wait;
	logic                  resp_err;
	logic                  hit_taken;
	fetch_pkg::inst_t      lane;

	assign pc_in_sram = (pc >= `UNCACHED_BASE) && (pc < `UNCACHED_LIMIT);
	assign bus_wait   = (state == fetch_pkg::IF_REFILL) || (state == fetch_pkg::IF_BYPASS);
	assign resp_err   = if_resp[1];
	assign hit_taken  = (state == fetch_pkg::IF_LOOKUP) && probe_done && hit;
	assign lane       = pc_q[2] ? if_rdata[63:32] : if_rdata[31:0];

	assign fetch_ready = state == fetch_pkg::IF_IDLE;
	assign inst_valid  = state == fetch_pkg::IF_DELIVER;
	assign lookup_addr = pc_q;

	assign if_valid = bus_wait && !req_sent;
	assign if_addr  = pc_q;

	// Refill writes the cache on the response edge, never on an error
	assign fill_en   = (state == fetch_pkg::IF_REFILL) && if_rvalid && !resp_err;
	assign fill_addr = pc_q;
	assign fill_beat = if_rdata;

	always_ff @(posedge clock) begin
		if (reset) begin
			state      <= fetch_pkg::IF_IDLE;
			probe_done <= 1'b0;
			req_sent   <= 1'b0;
			inst_err   <= 1'b0;
		end else begin
			case (state)
			fetch_pkg::IF_IDLE: begin
				if (fetch_valid) begin
					state <= pc_in_sram ? fetch_pkg::IF_BYPASS : fetch_pkg::IF_LOOKUP;
				end
			end
			fetch_pkg::IF_LOOKUP: begin
				probe_done <= !probe_done;
				if (probe_done) begin
					inst_err <= 1'b0;
					state    <= hit ? fetch_pkg::IF_DELIVER : fetch_pkg::IF_REFILL;
				end
			end
			fetch_pkg::IF_REFILL, fetch_pkg::IF_BYPASS: begin
				if (if_valid && if_ready) begin
					req_sent <= 1'b1;
				end
				if (if_rvalid) begin
					req_sent <= 1'b0;
					inst_err <= resp_err;
					state    <= fetch_pkg::IF_DELIVER;
				end
			end
			fetch_pkg::IF_DELIVER: begin
				if (inst_ready) state <= fetch_pkg::IF_IDLE; // Held until taken
			end
			default: state <= fetch_pkg::IF_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (fetch_valid && fetch_ready) begin
			pc_q <= pc;
		end
		if (hit_taken) begin
			inst <= hit_word;
		end else if (bus_wait && if_rvalid) begin
			inst <= resp_err ? '0 : lane;
		end
	end

endmodule

// File: src/mem_arbiter.sv
module mem_arbiter (
	input  logic              clock,
	input  logic              reset,

	input  logic              if_valid,
	output logic              if_ready,
	input  fetch_pkg::addr_t  if_addr,
	output logic              if_rvalid,
	output fetch_pkg::beat_t  if_rdata,
	output fetch_pkg::resp_t  if_resp,

	input  logic              lsu_valid,
	output logic              lsu_ready,
	input  logic              lsu_write,
	input  fetch_pkg::addr_t  lsu_addr,
	input  fetch_pkg::beat_t  lsu_wdata,
	output logic              lsu_rvalid,
	output fetch_pkg::beat_t  lsu_rdata,
	output fetch_pkg::resp_t  lsu_resp,

	output logic              mem_valid,
	input  logic              mem_ready,
	output logic              mem_write,
	output fetch_pkg::addr_t  mem_addr,
	output fetch_pkg::beat_t  mem_wdata,
	input  logic              mem_rvalid,
	input  fetch_pkg::beat_t  mem_rdata,
	input  fetch_pkg::resp_t  mem_resp
);

	logic              busy; // A request is out and its response is pending
	fetch_pkg::grant_t owner;
	fetch_pkg::grant_t prio;  // Wins when both ask
	fetch_pkg::grant_t sel;

	assign sel = (lsu_valid && (!if_valid || (prio == 1'b1))) ? 1'b1 : 1'b0;

	assign mem_valid = !busy && (if_valid || lsu_valid);
	assign mem_write = (sel == 1'b1) && lsu_write; // Fetches only read
	assign mem_addr  = (sel == 1'b1) ? lsu_addr : if_addr;
	assign mem_wdata = (sel == 1'b1) ? lsu_wdata : '0;

	assign if_ready  = !busy && (sel == 1'b0) && mem_ready;
	assign lsu_ready = !busy && (sel == 1'b1) && mem_ready;

	assign if_rvalid  = busy && mem_rvalid && (owner == 1'b0);
	assign lsu_rvalid = busy && mem_rvalid && (owner == 1'b1);
	assign if_rdata   = mem_rdata;
	assign lsu_rdata  = mem_rdata;
	assign if_resp    = mem_resp;
	assign lsu_resp   = mem_resp;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy  <= 1'b0;
			owner <= 1'b0;
			prio  <= 1'b0;
		end else if (mem_valid && mem_ready) begin
			busy  <= 1'b1;
			owner <= sel;
		end else if (busy && mem_rvalid) begin
			busy <= 1'b0;
			prio <= ~owner; // Other side goes first next time
		end
	end

endmodule

// File: src/main_memory.sv
`include "fetch_defines.svh"

module main_memory (
	input  logic             clock,
	input  logic             reset,
	input  logic             mem_valid,
	output logic             mem_ready,
	input  logic             mem_write,
	input  fetch_pkg::addr_t mem_addr,
	input  fetch_pkg::beat_t mem_wdata,
	output logic             mem_rvalid,
	output fetch_pkg::beat_t mem_rdata,
	output fetch_pkg::resp_t mem_resp
);

	localparam int INDEX_BITS = $clog2(`MEM_BEATS);
	localparam int CNT_BITS   = $clog2(`MEM_LATENCY + 1);

	fetch_pkg::mem_state_t state;
	logic [CNT_BITS-1:0]   count;
	fetch_pkg::beat_t      mem [`MEM_BEATS];

	logic                  req_write;
	fetch_pkg::addr_t      req_addr;
	fetch_pkg::beat_t      req_wdata;
	logic [INDEX_BITS-1:0] req_index;
	logic                  req_decoded;
	logic                  accept;
	logic                  respond;

	assign mem_ready = state == fetch_pkg::MEM_IDLE;
	assign accept    = mem_valid && mem_ready;
	assign respond   = (state == fetch_pkg::MEM_BUSY) && (count == CNT_BITS'(1));
	assign req_index = req_addr[INDEX_BITS+2:3];
	assign req_decoded = ((req_addr >= `UNCACHED_BASE) && (req_addr < `UNCACHED_LIMIT))
		|| ((req_addr >= `CACHED_BASE) && (req_addr < `CACHED_LIMIT));

	always_ff @(posedge clock) begin
		if (reset) begin
			state      <= fetch_pkg::MEM_IDLE;
			count      <= '0;
			mem_rvalid <= 1'b0;
		end else begin
			mem_rvalid <= respond;
			if (accept) begin
				state <= fetch_pkg::MEM_BUSY;
				count <= CNT_BITS'(`MEM_LATENCY);
			end else if (respond) begin
				state <= fetch_pkg::MEM_IDLE;
			end else if (state == fetch_pkg::MEM_BUSY) begin
				count <= count - CNT_BITS'(1);
			end
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			req_write <= mem_write;
			req_addr  <= mem_addr;
			req_wdata <= mem_wdata;
		end
		if (respond) begin
			if (req_decoded && req_write) mem[req_index] <= req_wdata;
			mem_rdata <= (req_decoded && !req_write) ? mem[req_index] : '0;
			mem_resp  <= req_decoded ? 2'b00 : 2'b10; // Undecoded gives an error
		end
	end

endmodule

// File: src/fetch_top.sv
module fetch_top (
	input  logic             clock,
	input  logic             reset,

	input  logic             fetch_valid,
	input  fetch_pkg::addr_t pc,
	output logic             fetch_ready,

	output logic             inst_valid,
	output fetch_pkg::inst_t inst,
	output logic             inst_err,
	input  logic             inst_ready,

	input  logic             lsu_valid,
	output logic             lsu_ready,
	input  logic             lsu_write,
	input  fetch_pkg::addr_t lsu_addr,
	input  fetch_pkg::beat_t lsu_wdata,
	output logic             lsu_rvalid,
	output fetch_pkg::beat_t lsu_rdata,
	output fetch_pkg::resp_t lsu_resp
);

	fetch_pkg::addr_t lookup_addr;
	logic             hit;
	fetch_pkg::inst_t hit_word;
	logic             fill_en;
	fetch_pkg::addr_t fill_addr;
	fetch_pkg::beat_t fill_beat;

	// Fetch side of the arbiter
	logic             if_valid;
	logic             if_ready;
	fetch_pkg::addr_t if_addr;
	logic             if_rvalid;
	fetch_pkg::beat_t if_rdata;
	fetch_pkg::resp_t if_resp;

	logic             mem_valid;
	logic             mem_ready;
	logic             mem_write;
	fetch_pkg::addr_t mem_addr;
	fetch_pkg::beat_t mem_wdata;
	logic             mem_rvalid;
	fetch_pkg::beat_t mem_rdata;
	fetch_pkg::resp_t mem_resp;

	ifu i_ifu (
		.clock       (clock),
		.reset       (reset),
		.fetch_valid (fetch_valid),
		.pc          (pc),
		.fetch_ready (fetch_ready),
		.inst_valid  (inst_valid),
		.inst        (inst),
		.inst_err    (inst_err),
		.inst_ready  (inst_ready),
		.lookup_addr (lookup_addr),
		.hit         (hit),
		.hit_word    (hit_word),
		.fill_en     (fill_en),
		.fill_addr   (fill_addr),
		.fill_beat   (fill_beat),
		.if_valid    (if_valid),
		.if_addr     (if_addr),
		.if_ready    (if_ready),
		.if_rvalid   (if_rvalid),
		.if_rdata    (if_rdata),
		.if_resp     (if_resp)
	);

	icache i_icache (
		.clock       (clock),
		.reset       (reset),
		.lookup_addr (lookup_addr),
		.hit         (hit),
		.hit_word    (hit_word),
		.fill_en     (fill_en),
		.fill_addr   (fill_addr),
		.fill_beat   (fill_beat)
	);

	mem_arbiter i_mem_arbiter (
		.clock      (clock),
		.reset      (reset),
		.if_valid   (if_valid),
		.if_ready   (if_ready),
		.if_addr    (if_addr),
		.if_rvalid  (if_rvalid),
		.if_rdata   (if_rdata),
		.if_resp    (if_resp),
		.lsu_valid  (lsu_valid),
		.lsu_ready  (lsu_ready),
		.lsu_write  (lsu_write),
		.lsu_addr   (lsu_addr),
		.lsu_wdata  (lsu_wdata),
		.lsu_rvalid (lsu_rvalid),
		.lsu_rdata  (lsu_rdata),
		.lsu_resp   (lsu_resp),
		.mem_valid  (mem_valid),
		.mem_ready  (mem_ready),
		.mem_write  (mem_write),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_rvalid (mem_rvalid),
		.mem_rdata  (mem_rdata),
		.mem_resp   (mem_resp)
	);

	main_memory i_main_memory (
		.clock      (clock),
		.reset      (reset),
		.mem_valid  (mem_valid),
		.mem_ready  (mem_ready),
		.mem_write  (mem_write),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_rvalid (mem_rvalid),
		.mem_rdata  (mem_rdata),
		.mem_resp   (mem_resp)
	);

endmodule

// File: verif/fetch_properties.sv
module fetch_properties (
	input logic             clock,
	input logic             reset,
	input logic             inst_valid,
	input logic             inst_ready,
	input fetch_pkg::inst_t inst,
	input logic             inst_err,
	input logic             mem_valid,
	input logic             mem_ready,
	input fetch_pkg::addr_t mem_addr
);
	timeunit 1ns;
	timeprecision 100ps;

	int failures; // Summed into the error total at the end of the run

	// A held instruction keeps its value under back-pressure
	assert property (@(posedge clock) disable iff (reset)
		inst_valid && !inst_ready |=> inst_valid && $stable(inst) && $stable(inst_err))
	else begin
		failures++;
		$error("inst or inst_err changed while the instruction was stalled");
	end

	assert property (@(posedge clock) disable iff (reset)
		mem_valid && !mem_ready |=> $stable(mem_addr))
	else begin
		failures++;
		$error("mem_addr changed while the request waited for mem_ready");
	end

	assert property (@(posedge clock) reset |=> !inst_valid)
	else begin
		failures++;
		$error("inst_valid high right after reset");
	end

endmodule

// File: verif/fetch_checker.sv
`include "fetch_defines.svh"

module fetch_checker (
	input  logic             clock,
	input  logic             reset,
	input  logic             fetch_valid,
	input  logic             fetch_ready,
	input  fetch_pkg::addr_t pc,
	input  logic             expect_hit,
	input  logic             inst_valid,
	input  logic             inst_ready,
	input  fetch_pkg::inst_t inst,
	input  logic             inst_err,
	input  fetch_pkg::beat_t shadow [`MEM_BEATS],
	output int               errors,
	output int               delivered
);
	timeunit 1ns;
	timeprecision 100ps;

	fetch_pkg::addr_t pc_queue [$];
	logic             hit_queue [$];
	int               stamp_queue [$]; // Cycle of each accepted fetch
	int               cycle;
	logic             timed;

	// Expected {error, word} for a PC, from the region decode and lane choice
	function automatic logic [32:0] predict_fetch(input fetch_pkg::addr_t addr);
		fetch_pkg::beat_t beat;
		logic             mapped;
		mapped = ((addr >= `UNCACHED_BASE) && (addr < `UNCACHED_LIMIT))
			|| ((addr >= `CACHED_BASE) && (addr < `CACHED_LIMIT));
		beat = shadow[addr[10:3]]; // Both regions alias the same beats
		if (!mapped) begin
			return {1'b1, 32'h0};
		end
		return {1'b0, addr[2] ? beat[63:32] : beat[31:0]};
	endfunction

	// Sampled mid-cycle, away from the edge where the DUT updates
	always @(negedge clock) begin
		logic [32:0]      want;
		fetch_pkg::addr_t addr;
		cycle = cycle + 1;
		if (reset) begin
			timed = 1'b0;
			pc_queue.delete();
			hit_queue.delete();
			stamp_queue.delete();
		end else begin
			if (fetch_valid && fetch_ready) begin
				pc_queue.push_back(pc);
				hit_queue.push_back(expect_hit);
				stamp_queue.push_back(cycle + 1); // Accepted on the next rising edge
			end
			if (inst_valid && !timed && pc_queue.size() != 0) begin
				timed = 1'b1;
				if (hit_queue[0] && (cycle - stamp_queue[0] != 2)) begin
					$display("FAIL t=%0t inst_valid latency: got %0d cycles, expected 2 (pc %h)",
						$time, cycle - stamp_queue[0], pc_queue[0]);
					errors++;
				end
			end
			if (inst_valid && inst_ready) begin
				timed = 1'b0;
				delivered++;
				if (pc_queue.size() == 0) begin
					$display("Instruction delivered at %0t with no accepted fetch pending", $time);
					errors++;
				end else begin
					addr = pc_queue.pop_front();
					hit_queue.delete(0);
					stamp_queue.delete(0);
					want = predict_fetch(addr);
					if (inst_err !== want[32]) begin
						$display("FAIL t=%0t inst_err: got %b expected %b (pc %h)",
							$time, inst_err, want[32], addr);
						errors++;
					end
					if (inst !== want[31:0]) begin
						$display("FAIL t=%0t inst: got %h expected %h (pc %h)",
							$time, inst, want[31:0], addr);
						errors++;
					end
				end
			end
		end
	end

endmodule

// File: verif/fetch_tb.sv
`include "fetch_defines.svh"

module fetch_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int PERIOD      = 4;
	localparam int STREAM      = 40;          // Fetches under random back-pressure
	localparam int FETCHES     = 32 + STREAM;
	localparam int LOAD_CYCLES = `MEM_BEATS * 8;
	localparam int LSU_READS   = 12;

	logic             clock;
	logic             reset;
	logic             fetch_valid;
	fetch_pkg::addr_t pc;
	logic             fetch_ready;
	logic             inst_valid;
	fetch_pkg::inst_t inst;
	logic             inst_err;
	logic             inst_ready;
	logic             lsu_valid;
	logic             lsu_ready;
	logic             lsu_write;
	fetch_pkg::addr_t lsu_addr;
	fetch_pkg::beat_t lsu_wdata;
	logic             lsu_rvalid;
	fetch_pkg::beat_t lsu_rdata;
	fetch_pkg::resp_t lsu_resp;

	logic             expect_hit;
	logic             stall;
	logic [31:0]      lfsr;
	fetch_pkg::beat_t shadow [`MEM_BEATS];
	fetch_pkg::addr_t stream_pcs [STREAM];
	fetch_pkg::addr_t read_addrs [LSU_READS];
	int               issued;
	int               tb_errors;
	int               check_errors;
	int               delivered;

	fetch_top i_fetch_top (.*);

	fetch_checker i_fetch_checker (
		.clock       (clock),
		.reset       (reset),
		.fetch_valid (fetch_valid),
		.fetch_ready (fetch_ready),
		.pc          (pc),
		.expect_hit  (expect_hit),
		.inst_valid  (inst_valid),
		.inst_ready  (inst_ready),
		.inst        (inst),
		.inst_err    (inst_err),
		.shadow      (shadow),
		.errors      (check_errors),
		.delivered   (delivered)
	);

	bind fetch_top fetch_properties i_fetch_properties (
		.clock      (clock),
		.reset      (reset),
		.inst_valid (inst_valid),
		.inst_ready (inst_ready),
		.inst       (inst),
		.inst_err   (inst_err),
		.mem_valid  (mem_valid),
		.mem_ready  (mem_ready),
		.mem_addr   (mem_addr)
	);

	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	function automatic logic [63:0] take_bits(input int count);
		logic [63:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr  = lfsr_step(lfsr);
			value = {value[62:0], lfsr[0]};
		end
		return value;
	endfunction

	// Kind 0 cached, 1 uncached window, otherwise just past the cached region
	function automatic fetch_pkg::addr_t random_pc(input int kind);
		fetch_pkg::addr_t offset;
		fetch_pkg::addr_t addr;
		offset = 32'(take_bits(11)) << 2;
		if (kind == 0) addr = `CACHED_BASE + (offset & 32'h7fc);
		else if (kind == 1) addr = `UNCACHED_BASE + offset;
		else addr = `CACHED_LIMIT + (offset & 32'h7fc);
		return addr;
	endfunction

	task automatic run_fetch(input fetch_pkg::addr_t addr, input logic hit_expected);
		logic done;
		fetch_valid = 1'b1;
		pc          = addr;
		expect_hit  = hit_expected;
		@(negedge clock);
		while (!fetch_ready) @(negedge clock);
		@(posedge clock);
		#1;
		fetch_valid = 1'b0;
		expect_hit  = 1'b0;
		issued++;
		done = 1'b0;
		while (!done) begin
			@(negedge clock);
			done = inst_valid && inst_ready;
			@(posedge clock);
			#1;
			if (stall) inst_ready = 1'(take_bits(1));
		end
	endtask

	task automatic lsu_access(input logic write, input fetch_pkg::addr_t addr,
			input fetch_pkg::beat_t data, output fetch_pkg::beat_t rdata,
			output fetch_pkg::resp_t resp);
		lsu_valid = 1'b1;
		lsu_write = write;
		lsu_addr  = addr;
		lsu_wdata = data;
		@(negedge clock);
		while (!lsu_ready) @(negedge clock);
		@(posedge clock);
		#1;
		lsu_valid = 1'b0;
		@(negedge clock);
		while (!lsu_rvalid) @(negedge clock);
		rdata = lsu_rdata;
		resp  = lsu_resp;
		@(posedge clock);
		#1;
	endtask

	initial begin
		fetch_pkg::addr_t a;
		fetch_pkg::addr_t b;
		fetch_pkg::beat_t rdata;
		fetch_pkg::resp_t resp;
		int               kind;
		lfsr        = 32'hae02_8e1b;
		reset       = 1'b1;
		fetch_valid = 1'b0;
		pc          = '0;
		inst_ready  = 1'b1;
		lsu_valid   = 1'b0;
		lsu_write   = 1'b0;
		lsu_addr    = '0;
		lsu_wdata   = '0;
		expect_hit  = 1'b0;
		stall       = 1'b0;
		repeat (4) @(posedge clock);
		#1;
		reset = 1'b0;

		for (int i = 0; i < `MEM_BEATS; i++) begin
			shadow[i] = take_bits(64);
			lsu_access(1'b1, `CACHED_BASE + 32'(i) * 8, shadow[i], rdata, resp);
		end

		// Miss first, then repeats that must hit
		for (int n = 0; n < 4; n++) begin
			a = random_pc(0);
			run_fetch(a, 1'b0);
			run_fetch(a, 1'b1);
			run_fetch(a, 1'b1);
		end
		repeat (6) run_fetch(random_pc(1), 1'b0);

		run_fetch(`UNCACHED_LIMIT, 1'b0);
		run_fetch(random_pc(2), 1'b0);
		run_fetch(32'h0, 1'b0);
		a = random_pc(0);
		run_fetch(a, 1'b0);
		run_fetch(a, 1'b1);

		a = `CACHED_BASE + 32'h248;
		b = a ^ 32'h80; // Same line index, other tag
		run_fetch(a, 1'b0);
		run_fetch(a, 1'b1);
		run_fetch(b, 1'b0);
		run_fetch(a, 1'b0);
		run_fetch(b, 1'b0);

		for (int n = 0; n < STREAM; n++) begin
			kind = int'(take_bits(2));
			stream_pcs[n] = random_pc(kind == 3 ? 0 : kind);
		end
		for (int n = 0; n < LSU_READS; n++) begin
			read_addrs[n] = random_pc(n % 2) & ~32'h7;
		end
		stall = 1'b1;
		fork
			for (int n = 0; n < STREAM; n++) begin
				run_fetch(stream_pcs[n], 1'b0);
			end
			for (int n = 0; n < LSU_READS; n++) begin
				lsu_access(1'b0, read_addrs[n], '0, rdata, resp);
				if (resp !== 2'b00 || rdata !== shadow[read_addrs[n][10:3]]) begin
					$display("FAIL t=%0t lsu_rdata: got %h resp %0d, expected %h resp 0",
						$time, rdata, resp, shadow[read_addrs[n][10:3]]);
					tb_errors++;
				end
				repeat (3) @(posedge clock);
				#1;
			end
		join
		stall      = 1'b0;
		inst_ready = 1'b1;
		repeat (2) @(posedge clock);

		if (delivered != issued) begin
			$display("Lost or extra instructions: %0d accepted, %0d delivered", issued, delivered);
			tb_errors++;
		end
		$display("Run done: %0d fetches, %0d fetch errors, %0d other errors, %0d assertion failures",
			issued, check_errors, tb_errors, i_fetch_top.i_fetch_properties.failures);
		if (check_errors + tb_errors + i_fetch_top.i_fetch_properties.failures == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	initial begin
		#((FETCHES * 40 + LOAD_CYCLES) * PERIOD);
		$display("Timeout: the run did not finish within %0d ns",
			(FETCHES * 40 + LOAD_CYCLES) * PERIOD);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: sim.f
+incdir+src
src/fetch_pkg.sv
src/icache.sv
src/ifu.sv
src/mem_arbiter.sv
src/main_memory.sv
src/fetch_top.sv
verif/fetch_properties.sv
verif/fetch_checker.sv
verif/fetch_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP      = fetch_tb
FILELIST = sim.f
OBJ_DIR  = obj_dir
RUN_ARGS = +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; echo "$$out"; \
		echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
